// File: verilog/lc3b_pkg.sv
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;         // {n, z, p}

    // only the opcodes this core executes, everything else is a no-op
    typedef enum logic [3:0] {
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001,
        op_shf = 4'b1101
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_pass,
        alu_add,
        alu_and,
        alu_not,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    parameter lc3b_nzp CC_RESET = 3'b010;  // zero set

    parameter int IMM_FLAG_BIT  = 5;       // add/and immediate mode
    parameter int SHF_DIR_BIT   = 4;       // shf: 0 left, 1 right
    parameter int SHF_ARITH_BIT = 5;       // shf right: 1 arithmetic

endpackage : lc3b_pkg

// File: verilog/lc3b_intake.sv
`timescale 1ns/1ps

module lc3b_intake
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              instr_req,
    input  lc3b_pkg::lc3b_word instr,
    output logic              instr_ack,
    input  logic              decode_ready,
    output logic              issue_valid,
    output lc3b_pkg::lc3b_word issue_instr
);

    typedef enum logic [1:0] {
        st_idle,
        st_acked,
        st_release
    } intake_state_t;

    intake_state_t state;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= st_idle;
        else
        begin
            case (state)
                st_idle:
                    if (instr_req && decode_ready)
                        state <= st_acked;              // word taken this edge
                st_acked:
                    if (!instr_req)
                        state <= st_release;            // req seen low
                default:
                    state <= st_idle;                   // ack drops here
            endcase
        end
    end

    assign instr_ack   = (state != st_idle);
    assign issue_valid = (state == st_idle) && instr_req && decode_ready;
    assign issue_instr = instr;                         // held stable by source

    // ack may only come up in answer to a request
    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(instr_ack) |-> $past(instr_req));

endmodule : lc3b_intake

// File: verilog/lc3b_decode.sv
`timescale 1ns/1ps

module lc3b_decode
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue_valid,
    input  lc3b_pkg::lc3b_word  issue_instr,
    output logic                decode_ready,
    output lc3b_pkg::lc3b_reg   rd_src_a,
    output lc3b_pkg::lc3b_reg   rd_src_b,
    input  lc3b_pkg::lc3b_word  rd_data_a,
    input  lc3b_pkg::lc3b_word  rd_data_b,
    input  lc3b_pkg::lc3b_reg   ex_pending_dest,
    input  logic                ex_pending,
    input  lc3b_pkg::lc3b_reg   mem_pending_dest,
    input  logic                mem_pending,
    output logic                ex_valid,
    output lc3b_pkg::lc3b_aluop ex_aluop,
    output lc3b_pkg::lc3b_word  ex_op_a,
    output lc3b_pkg::lc3b_word  ex_op_b,
    output lc3b_pkg::lc3b_reg   ex_dest,
    output logic                ex_writes,
    output logic                ex_is_load,
    output logic                ex_is_store,
    output lc3b_pkg::lc3b_word  ex_store_data
);

    lc3b_pkg::lc3b_word   ir;
    logic                 ir_valid;
    lc3b_pkg::lc3b_opcode opcode;
    logic                 imm_mode;
    lc3b_pkg::lc3b_word   imm5_sext;
    lc3b_pkg::lc3b_word   imm4_zext;
    lc3b_pkg::lc3b_word   offset6_adj;
    logic                 uses_a;
    logic                 uses_b;
    logic                 hit_a;
    logic                 hit_b;
    logic                 stall;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ir_valid <= 1'b0;
        else if (decode_ready)
            ir_valid <= issue_valid;
    end

    always_ff @(posedge clk)
    begin
        if (decode_ready && issue_valid)
            ir <= issue_instr;
    end

    assign opcode      = lc3b_pkg::lc3b_opcode'(ir[15:12]);
    assign imm_mode    = ir[lc3b_pkg::IMM_FLAG_BIT];
    assign imm5_sext   = {{11{ir[4]}}, ir[4:0]};
    assign imm4_zext   = {12'b0, ir[3:0]};
    assign offset6_adj = {{9{ir[5]}}, ir[5:0], 1'b0};   // word offset

    assign rd_src_a = ir[8:6];
    assign rd_src_b = (opcode == lc3b_pkg::op_str) ? ir[11:9] : ir[2:0];

    always_comb
    begin
        ex_aluop    = lc3b_pkg::alu_pass;
        ex_op_b     = rd_data_b;
        ex_writes   = 1'b0;
        ex_is_load  = 1'b0;
        ex_is_store = 1'b0;
        uses_a      = 1'b1;
        uses_b      = 1'b0;
        case (opcode)
            lc3b_pkg::op_add, lc3b_pkg::op_and:
            begin
                ex_aluop  = (opcode == lc3b_pkg::op_add) ? lc3b_pkg::alu_add
                                                         : lc3b_pkg::alu_and;
                ex_op_b   = imm_mode ? imm5_sext : rd_data_b;
                ex_writes = 1'b1;
                uses_b    = !imm_mode;
            end
            lc3b_pkg::op_not:
            begin
                ex_aluop  = lc3b_pkg::alu_not;
                ex_writes = 1'b1;
            end
            lc3b_pkg::op_shf:
            begin
                if (!ir[lc3b_pkg::SHF_DIR_BIT])
                    ex_aluop = lc3b_pkg::alu_sll;
                else if (ir[lc3b_pkg::SHF_ARITH_BIT])
                    ex_aluop = lc3b_pkg::alu_sra;
                else
                    ex_aluop = lc3b_pkg::alu_srl;
                ex_op_b   = imm4_zext;
                ex_writes = 1'b1;
            end
            lc3b_pkg::op_ldr:
            begin
                ex_aluop   = lc3b_pkg::alu_add;           // base + offset
                ex_op_b    = offset6_adj;
                ex_writes  = 1'b1;
                ex_is_load = 1'b1;
            end
            lc3b_pkg::op_str:
            begin
                ex_aluop    = lc3b_pkg::alu_add;
                ex_op_b     = offset6_adj;
                ex_is_store = 1'b1;
                uses_b      = 1'b1;                       // store data via port b
            end
            default:
                uses_a = 1'b0;                            // no-op, reads nothing
        endcase
    end

    assign ex_op_a       = rd_data_a;
    assign ex_dest       = ir[11:9];
    assign ex_store_data = rd_data_b;

    // writeback stage is covered by regfile write-through
    assign hit_a = (ex_pending && ex_pending_dest == rd_src_a) ||
                   (mem_pending && mem_pending_dest == rd_src_a);
    assign hit_b = (ex_pending && ex_pending_dest == rd_src_b) ||
                   (mem_pending && mem_pending_dest == rd_src_b);

    assign stall        = ir_valid && ((uses_a && hit_a) || (uses_b && hit_b));
    assign decode_ready = !stall;
    assign ex_valid     = ir_valid && !stall;         // bubble while stalled

    // a stall clears within two cycles
    stall_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        stall |-> ##[1:2] ex_valid);

endmodule : lc3b_decode

// File: verilog/lc3b_regfile.sv
`timescale 1ns/1ps

module lc3b_regfile
(
    input  logic               clk,
    input  logic               arst_n,
    input  lc3b_pkg::lc3b_reg  rd_src_a,
    input  lc3b_pkg::lc3b_reg  rd_src_b,
    output lc3b_pkg::lc3b_word rd_data_a,
    output lc3b_pkg::lc3b_word rd_data_b,
    input  logic               wr_en,
    input  lc3b_pkg::lc3b_reg  wr_dest,
    input  lc3b_pkg::lc3b_word wr_data
);

    lc3b_pkg::lc3b_word regs [8];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[wr_dest] <= wr_data;
    end

    // write-through so decode sees the value being written back
    assign rd_data_a = (wr_en && wr_dest == rd_src_a) ? wr_data : regs[rd_src_a];
    assign rd_data_b = (wr_en && wr_dest == rd_src_b) ? wr_data : regs[rd_src_b];

endmodule : lc3b_regfile

// File: verilog/lc3b_execute.sv
`timescale 1ns/1ps

module lc3b_execute
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ex_valid,
    input  lc3b_pkg::lc3b_aluop ex_aluop,
    input  lc3b_pkg::lc3b_word  ex_op_a,
    input  lc3b_pkg::lc3b_word  ex_op_b,
    input  lc3b_pkg::lc3b_reg   ex_dest,
    input  logic                ex_writes,
    input  logic                ex_is_load,
    input  logic                ex_is_store,
    input  lc3b_pkg::lc3b_word  ex_store_data,
    output logic                mem_valid,
    output lc3b_pkg::lc3b_word  mem_result,
    output lc3b_pkg::lc3b_reg   mem_dest,
    output logic                mem_writes,
    output logic                mem_is_load,
    output logic                mem_is_store,
    output lc3b_pkg::lc3b_word  mem_store_data
);

    logic                valid_q;
    logic                writes_q;
    logic                is_load_q;
    logic                is_store_q;
    lc3b_pkg::lc3b_aluop aluop_q;
    lc3b_pkg::lc3b_word  op_a_q;
    lc3b_pkg::lc3b_word  op_b_q;
    lc3b_pkg::lc3b_reg   dest_q;
    lc3b_pkg::lc3b_word  store_data_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_q    <= 1'b0;
            writes_q   <= 1'b0;
            is_load_q  <= 1'b0;
            is_store_q <= 1'b0;
        end
        else
        begin
            valid_q    <= ex_valid;
            writes_q   <= ex_writes;
            is_load_q  <= ex_is_load;
            is_store_q <= ex_is_store;
        end
    end

    always_ff @(posedge clk)
    begin
        aluop_q      <= ex_aluop;
        op_a_q       <= ex_op_a;
        op_b_q       <= ex_op_b;
        dest_q       <= ex_dest;
        store_data_q <= ex_store_data;
    end

    always_comb
    begin
        case (aluop_q)
            lc3b_pkg::alu_add:  mem_result = op_a_q + op_b_q;
            lc3b_pkg::alu_and:  mem_result = op_a_q & op_b_q;
            lc3b_pkg::alu_not:  mem_result = ~op_a_q;
            lc3b_pkg::alu_sll:  mem_result = op_a_q << op_b_q[3:0];
            lc3b_pkg::alu_srl:  mem_result = op_a_q >> op_b_q[3:0];
            lc3b_pkg::alu_sra:  mem_result = $signed(op_a_q) >>> op_b_q[3:0];
            lc3b_pkg::alu_pass: mem_result = op_a_q;
            default:            mem_result = op_a_q;
        endcase
    end

    assign mem_valid      = valid_q;
    assign mem_dest       = dest_q;
    assign mem_writes     = valid_q && writes_q;   // also a pending write for decode
    assign mem_is_load    = is_load_q;
    assign mem_is_store   = is_store_q;
    assign mem_store_data = store_data_q;

endmodule : lc3b_execute

// File: verilog/lc3b_memory.sv
`timescale 1ns/1ps

module lc3b_memory
#(
    parameter int DMEM_ADDR_BITS = 6
)
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               mem_valid,
    input  lc3b_pkg::lc3b_word mem_result,
    input  lc3b_pkg::lc3b_reg  mem_dest,
    input  logic               mem_writes,
    input  logic               mem_is_load,
    input  logic               mem_is_store,
    input  lc3b_pkg::lc3b_word mem_store_data,
    output logic               wb_in_valid,
    output lc3b_pkg::lc3b_word wb_in_data,
    output lc3b_pkg::lc3b_reg  wb_in_dest,
    output logic               wb_in_writes
);

    logic                      valid_q;
    logic                      writes_q;
    logic                      is_load_q;
    logic                      is_store_q;
    lc3b_pkg::lc3b_word        result_q;
    lc3b_pkg::lc3b_reg         dest_q;
    lc3b_pkg::lc3b_word        store_data_q;
    lc3b_pkg::lc3b_word        dmem [2**DMEM_ADDR_BITS];
    logic [DMEM_ADDR_BITS-1:0] addr;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_q    <= 1'b0;
            writes_q   <= 1'b0;
            is_load_q  <= 1'b0;
            is_store_q <= 1'b0;
        end
        else
        begin
            valid_q    <= mem_valid;
            writes_q   <= mem_writes;
            is_load_q  <= mem_is_load;
            is_store_q <= mem_is_store;
        end
    end

    always_ff @(posedge clk)
    begin
        result_q     <= mem_result;
        dest_q       <= mem_dest;
        store_data_q <= mem_store_data;
    end

    assign addr = result_q[DMEM_ADDR_BITS:1];          // word address

    always_ff @(posedge clk)
    begin
        if (valid_q && is_store_q)
            dmem[addr] <= store_data_q;                 // end of memory stage
    end

    assign wb_in_valid  = valid_q;
    assign wb_in_data   = is_load_q ? dmem[addr] : result_q;
    assign wb_in_dest   = dest_q;
    assign wb_in_writes = valid_q && writes_q;

    // decode never marks one instruction as both load and store
    one_mem_access: assert property (@(posedge clk) disable iff (!arst_n)
        valid_q |-> !(is_load_q && is_store_q));

endmodule : lc3b_memory

// File: verilog/lc3b_writeback.sv
`timescale 1ns/1ps

module lc3b_writeback
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               wb_in_valid,
    input  lc3b_pkg::lc3b_word wb_in_data,
    input  lc3b_pkg::lc3b_reg  wb_in_dest,
    input  logic               wb_in_writes,
    output logic               wr_en,
    output lc3b_pkg::lc3b_reg  wr_dest,
    output lc3b_pkg::lc3b_word wr_data,
    output logic               wb_valid,
    output lc3b_pkg::lc3b_reg  wb_dest,
    output lc3b_pkg::lc3b_word wb_data,
    output lc3b_pkg::lc3b_nzp  cc
);

    lc3b_pkg::lc3b_nzp nzp_next;
    logic              take;

    assign take = wb_in_valid && wb_in_writes;

    always_comb
    begin
        if (wb_in_data[15])
            nzp_next = 3'b100;
        else if (wb_in_data == '0)
            nzp_next = 3'b010;
        else
            nzp_next = 3'b001;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_valid <= 1'b0;
            cc       <= lc3b_pkg::CC_RESET;
        end
        else
        begin
            wb_valid <= take;                           // one cycle per write
            if (take)
                cc <= nzp_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            wb_dest <= wb_in_dest;
            wb_data <= wb_in_data;
        end
    end

    assign wr_en   = wb_valid;
    assign wr_dest = wb_dest;
    assign wr_data = wb_data;

endmodule : lc3b_writeback

// File: verilog/lc3b_pipeline.sv
`timescale 1ns/1ps

module lc3b_pipeline
#(
    parameter int DMEM_ADDR_BITS = 6
)
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               instr_req,
    input  lc3b_pkg::lc3b_word instr,
    output logic               instr_ack,
    output logic               wb_valid,
    output lc3b_pkg::lc3b_reg  wb_dest,
    output lc3b_pkg::lc3b_word wb_data,
    output lc3b_pkg::lc3b_nzp  cc
);

    logic                issue_valid;
    lc3b_pkg::lc3b_word  issue_instr;
    logic                decode_ready;

    lc3b_pkg::lc3b_reg   rd_src_a;
    lc3b_pkg::lc3b_reg   rd_src_b;
    lc3b_pkg::lc3b_word  rd_data_a;
    lc3b_pkg::lc3b_word  rd_data_b;

    logic                ex_valid;
    lc3b_pkg::lc3b_aluop ex_aluop;
    lc3b_pkg::lc3b_word  ex_op_a;
    lc3b_pkg::lc3b_word  ex_op_b;
    lc3b_pkg::lc3b_reg   ex_dest;
    logic                ex_writes;
    logic                ex_is_load;
    logic                ex_is_store;
    lc3b_pkg::lc3b_word  ex_store_data;

    logic                mem_valid;
    lc3b_pkg::lc3b_word  mem_result;
    lc3b_pkg::lc3b_reg   mem_dest;
    logic                mem_writes;
    logic                mem_is_load;
    logic                mem_is_store;
    lc3b_pkg::lc3b_word  mem_store_data;

    logic                wb_in_valid;
    lc3b_pkg::lc3b_word  wb_in_data;
    lc3b_pkg::lc3b_reg   wb_in_dest;
    logic                wb_in_writes;

    logic                wr_en;
    lc3b_pkg::lc3b_reg   wr_dest;
    lc3b_pkg::lc3b_word  wr_data;

    lc3b_intake intake0
    (
        .clk(clk), .arst_n(arst_n),
        .instr_req(instr_req), .instr(instr), .instr_ack(instr_ack),
        .decode_ready(decode_ready),
        .issue_valid(issue_valid), .issue_instr(issue_instr)
    );

    // scoreboard watches the execute and memory stage registers
    lc3b_decode decode0
    (
        .clk(clk), .arst_n(arst_n),
        .issue_valid(issue_valid), .issue_instr(issue_instr),
        .decode_ready(decode_ready),
        .rd_src_a(rd_src_a), .rd_src_b(rd_src_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .ex_pending_dest(mem_dest), .ex_pending(mem_writes),
        .mem_pending_dest(wb_in_dest), .mem_pending(wb_in_writes),
        .ex_valid(ex_valid), .ex_aluop(ex_aluop),
        .ex_op_a(ex_op_a), .ex_op_b(ex_op_b),
        .ex_dest(ex_dest), .ex_writes(ex_writes),
        .ex_is_load(ex_is_load), .ex_is_store(ex_is_store),
        .ex_store_data(ex_store_data)
    );

    lc3b_regfile regfile0
    (
        .clk(clk), .arst_n(arst_n),
        .rd_src_a(rd_src_a), .rd_src_b(rd_src_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wr_en(wr_en), .wr_dest(wr_dest), .wr_data(wr_data)
    );

    lc3b_execute execute0
    (
        .clk(clk), .arst_n(arst_n),
        .ex_valid(ex_valid), .ex_aluop(ex_aluop),
        .ex_op_a(ex_op_a), .ex_op_b(ex_op_b),
        .ex_dest(ex_dest), .ex_writes(ex_writes),
        .ex_is_load(ex_is_load), .ex_is_store(ex_is_store),
        .ex_store_data(ex_store_data),
        .mem_valid(mem_valid), .mem_result(mem_result),
        .mem_dest(mem_dest), .mem_writes(mem_writes),
        .mem_is_load(mem_is_load), .mem_is_store(mem_is_store),
        .mem_store_data(mem_store_data)
    );

    lc3b_memory #(.DMEM_ADDR_BITS(DMEM_ADDR_BITS)) memory0
    (
        .clk(clk), .arst_n(arst_n),
        .mem_valid(mem_valid), .mem_result(mem_result),
        .mem_dest(mem_dest), .mem_writes(mem_writes),
        .mem_is_load(mem_is_load), .mem_is_store(mem_is_store),
        .mem_store_data(mem_store_data),
        .wb_in_valid(wb_in_valid), .wb_in_data(wb_in_data),
        .wb_in_dest(wb_in_dest), .wb_in_writes(wb_in_writes)
    );

    lc3b_writeback writeback0
    (
        .clk(clk), .arst_n(arst_n),
        .wb_in_valid(wb_in_valid), .wb_in_data(wb_in_data),
        .wb_in_dest(wb_in_dest), .wb_in_writes(wb_in_writes),
        .wr_en(wr_en), .wr_dest(wr_dest), .wr_data(wr_data),
        .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data),
        .cc(cc)
    );

endmodule : lc3b_pipeline

// File: tb/lc3b_clock_gen.sv
`timescale 1ns/1ps

module lc3b_clock_gen
#(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
)
(
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;                                  // release away from the rising edge
    end

endmodule : lc3b_clock_gen

// File: tb/lc3b_pipeline_tb.sv
`timescale 1ns/1ps

module lc3b_pipeline_tb;

    localparam int DMEM_ADDR_BITS = 6;
    localparam int MEM_WORDS      = 2**DMEM_ADDR_BITS;
    localparam int DRIVE_DELAY    = 1;
    localparam int INSTR_COUNT    = 87;                 // 20 + 16 + 16 + 17 + 12 + 6
    localparam int CYCLE_LIMIT    = INSTR_COUNT * 12 + 100;

    logic               clk;
    logic               arst_n;
    logic               instr_req;
    lc3b_pkg::lc3b_word instr;
    logic               instr_ack;
    logic               wb_valid;
    lc3b_pkg::lc3b_reg  wb_dest;
    lc3b_pkg::lc3b_word wb_data;
    lc3b_pkg::lc3b_nzp  cc;

    logic [15:0]        lfsr_state;
    lc3b_pkg::lc3b_word model_regs [8];
    lc3b_pkg::lc3b_word model_mem  [MEM_WORDS];
    lc3b_pkg::lc3b_nzp  model_cc;

    // expected writes in program order
    lc3b_pkg::lc3b_reg  exp_dest_q [$];
    lc3b_pkg::lc3b_word exp_data_q [$];
    lc3b_pkg::lc3b_nzp  exp_cc_q   [$];
    string              exp_name_q [$];

    string test_name;
    int    checks       = 0;
    int    errors       = 0;
    int    checks_start = 0;
    int    errors_start = 0;
    int    cycles       = 0;

    lc3b_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(5)) clock0
    (
        .clk(clk),
        .arst_n(arst_n)
    );

    lc3b_pipeline #(.DMEM_ADDR_BITS(DMEM_ADDR_BITS)) dut0
    (
        .clk(clk), .arst_n(arst_n),
        .instr_req(instr_req), .instr(instr), .instr_ack(instr_ack),
        .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data),
        .cc(cc)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic lc3b_pkg::lc3b_reg rand_reg();
        logic [15:0] v;
        v = rand_bits(3);
        return v[2:0];
    endfunction

    function automatic lc3b_pkg::lc3b_word alu_reg_word(input lc3b_pkg::lc3b_opcode op,
        input lc3b_pkg::lc3b_reg dr, input lc3b_pkg::lc3b_reg sr1,
        input lc3b_pkg::lc3b_reg sr2);
        return {op, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic lc3b_pkg::lc3b_word alu_imm_word(input lc3b_pkg::lc3b_opcode op,
        input lc3b_pkg::lc3b_reg dr, input lc3b_pkg::lc3b_reg sr1, input logic [15:0] imm);
        return {op, dr, sr1, 1'b1, imm[4:0]};
    endfunction

    function automatic lc3b_pkg::lc3b_word not_word(input lc3b_pkg::lc3b_reg dr,
        input lc3b_pkg::lc3b_reg sr);
        return {lc3b_pkg::op_not, dr, sr, 6'b111111};
    endfunction

    function automatic lc3b_pkg::lc3b_word shift_word(input lc3b_pkg::lc3b_reg dr,
        input lc3b_pkg::lc3b_reg sr, input logic arith, input logic right,
        input logic [15:0] amt);
        return {lc3b_pkg::op_shf, dr, sr, arith, right, amt[3:0]};
    endfunction

    function automatic lc3b_pkg::lc3b_word mem_word(input lc3b_pkg::lc3b_opcode op,
        input lc3b_pkg::lc3b_reg r, input lc3b_pkg::lc3b_reg base, input logic [15:0] off);
        return {op, r, base, off[5:0]};
    endfunction

    // reference model of the ISA subset
    function automatic void model_execute(input lc3b_pkg::lc3b_word w);
        logic [3:0]                op;
        lc3b_pkg::lc3b_reg         dr;
        lc3b_pkg::lc3b_word        a;
        lc3b_pkg::lc3b_word        b;
        lc3b_pkg::lc3b_word        res;
        lc3b_pkg::lc3b_word        addr;
        logic [DMEM_ADDR_BITS-1:0] idx;
        logic                      writes;
        op     = w[15:12];
        dr     = w[11:9];
        a      = model_regs[w[8:6]];
        b      = w[5] ? {{11{w[4]}}, w[4:0]} : model_regs[w[2:0]];
        addr   = a + {{9{w[5]}}, w[5:0], 1'b0};       // byte address of a word
        idx    = addr[DMEM_ADDR_BITS:1];
        res    = '0;
        writes = 1'b1;
        case (op)
            lc3b_pkg::op_add: res = a + b;
            lc3b_pkg::op_and: res = a & b;
            lc3b_pkg::op_not: res = ~a;
            lc3b_pkg::op_shf:
            begin
                if (!w[4])
                    res = a << w[3:0];
                else if (w[5])
                    res = $signed(a) >>> w[3:0];
                else
                    res = a >> w[3:0];
            end
            lc3b_pkg::op_ldr: res = model_mem[idx];
            lc3b_pkg::op_str:
            begin
                model_mem[idx] = model_regs[dr];
                writes = 1'b0;
            end
            default: writes = 1'b0;                     // anything else is a no-op
        endcase
        if (writes)
        begin
            model_regs[dr] = res;
            if (res[15])
                model_cc = 3'b100;
            else if (res == '0)
                model_cc = 3'b010;
            else
                model_cc = 3'b001;
            exp_dest_q.push_back(dr);
            exp_data_q.push_back(res);
            exp_cc_q.push_back(model_cc);
            exp_name_q.push_back(test_name);
        end
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
        input logic [15:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // called a short delay after a rising edge, returns the same way
    task automatic send_instr(input lc3b_pkg::lc3b_word w);
        instr     = w;
        instr_req = 1'b1;
        model_execute(w);
        while (!instr_ack)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        instr_req = 1'b0;
        while (instr_ack)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        checks_start = checks;
        errors_start = errors;
    endtask

    task automatic end_test();
        while (exp_data_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);                      // catch stray reports
        #DRIVE_DELAY;
        $display("test %s: %0d checks, %0d errors", test_name,
                 checks - checks_start, errors - errors_start);
    endtask

    task automatic test_register_ops();
        for (int r = 0; r < 8; r++)
            send_instr(alu_imm_word(lc3b_pkg::op_add, r[2:0], r[2:0], rand_bits(5)));
        repeat (12)
            send_instr(alu_reg_word(rand_bits(1) != 0 ? lc3b_pkg::op_and : lc3b_pkg::op_add,
                                    rand_reg(), rand_reg(), rand_reg()));
    endtask

    task automatic test_imm_and_not();
        logic [15:0] sel;
        send_instr(alu_imm_word(lc3b_pkg::op_add, 3'd1, 3'd1, 16'hfff0));   // -16
        repeat (15)
        begin
            sel = rand_bits(2);
            if (sel == 0)
                send_instr(not_word(rand_reg(), rand_reg()));
            else if (sel == 1)
                send_instr(alu_imm_word(lc3b_pkg::op_and, rand_reg(), rand_reg(), rand_bits(5)));
            else
                send_instr(alu_imm_word(lc3b_pkg::op_add, rand_reg(), rand_reg(), rand_bits(5)));
        end
    endtask

    task automatic test_shifts();
        logic [15:0] sel;
        send_instr(not_word(3'd4, 3'd4));               // make sure one source is negative
        repeat (15)
        begin
            sel = rand_bits(2);
            if (sel == 0)
                send_instr(shift_word(rand_reg(), rand_reg(), 1'b0, 1'b0, rand_bits(4)));
            else if (sel == 1)
                send_instr(shift_word(rand_reg(), rand_reg(), 1'b0, 1'b1, rand_bits(4)));
            else
                send_instr(shift_word(rand_reg(), rand_reg(), 1'b1, 1'b1, rand_bits(4)));
        end
    endtask

    task automatic test_load_store();
        logic [15:0]       off;
        lc3b_pkg::lc3b_reg dest;
        send_instr(alu_imm_word(lc3b_pkg::op_and, 3'd6, 3'd6, 16'h0000));  // base r6 = 0
        repeat (8)
        begin
            off  = rand_bits(6);
            dest = rand_reg();
            if (dest == 3'd6)
                dest = 3'd7;                            // keep the base intact
            send_instr(mem_word(lc3b_pkg::op_str, rand_reg(), 3'd6, off));
            send_instr(mem_word(lc3b_pkg::op_ldr, dest, 3'd6, off));
        end
    endtask

    task automatic test_dependent_chain();
        lc3b_pkg::lc3b_reg prev;
        lc3b_pkg::lc3b_reg dest;
        logic [15:0]       sel;
        prev = rand_reg();
        repeat (12)
        begin
            dest = rand_reg();
            sel  = rand_bits(2);
            case (sel[1:0])
                2'd0: send_instr(alu_imm_word(lc3b_pkg::op_add, dest, prev, rand_bits(5)));
                2'd1: send_instr(alu_reg_word(lc3b_pkg::op_add, dest, prev, prev));
                2'd2: send_instr(not_word(dest, prev));
                default: send_instr(shift_word(dest, prev, 1'b1, 1'b1, rand_bits(4)));
            endcase
            prev = dest;                                // next one reads this result
        end
    endtask

    task automatic test_condition_codes();
        send_instr(alu_imm_word(lc3b_pkg::op_and, 3'd2, 3'd2, 16'h0000));  // zero
        send_instr(alu_imm_word(lc3b_pkg::op_add, 3'd2, 3'd2, 16'hfffb));  // -5
        send_instr(alu_imm_word(lc3b_pkg::op_add, 3'd2, 3'd2, 16'h0007));  // +2
        send_instr(16'h0000);                           // no-op, cc must hold
        send_instr(not_word(3'd3, 3'd2));
        send_instr(alu_imm_word(lc3b_pkg::op_and, 3'd3, 3'd3, 16'h0000));
    endtask

    always @(negedge clk)
    begin : compare_reports
        string              name;
        lc3b_pkg::lc3b_reg  dest;
        lc3b_pkg::lc3b_word data;
        lc3b_pkg::lc3b_nzp  nzp;
        if (arst_n && wb_valid)
        begin
            if (exp_data_q.size() == 0)
            begin
                errors++;
                $display("write report for r%0d arrived when no write was expected", wb_dest);
            end
            else
            begin
                name = exp_name_q.pop_front();
                dest = exp_dest_q.pop_front();
                data = exp_data_q.pop_front();
                nzp  = exp_cc_q.pop_front();
                check_value({name, " dest"}, {13'b0, dest}, {13'b0, wb_dest});
                check_value({name, " data"}, data, wb_data);
                check_value({name, " cc"}, {13'b0, nzp}, {13'b0, cc});
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    initial
    begin
        instr_req  = 1'b0;
        instr      = '0;
        lfsr_state = 16'd84;
        model_regs = '{default: '0};
        model_cc   = 3'b010;                            // zero-set out of reset
        wait (arst_n === 1'b1);
        @(posedge clk);
        #DRIVE_DELAY;

        start_test("reset");
        check_value("reset cc", {13'b0, 3'b010}, {13'b0, cc});
        check_value("reset instr_ack", 16'h0000, {15'b0, instr_ack});
        check_value("reset wb_valid", 16'h0000, {15'b0, wb_valid});
        end_test();

        start_test("register_ops");
        test_register_ops();
        end_test();
        start_test("imm_and_not");
        test_imm_and_not();
        end_test();
        start_test("shifts");
        test_shifts();
        end_test();
        start_test("load_store");
        test_load_store();
        end_test();
        start_test("dependent_chain");
        test_dependent_chain();
        end_test();
        start_test("condition_codes");
        test_condition_codes();
        end_test();

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule : lc3b_pipeline_tb

// File: lc3b_pipeline.f
verilog/lc3b_pkg.sv
verilog/lc3b_intake.sv
verilog/lc3b_decode.sv
verilog/lc3b_regfile.sv
verilog/lc3b_execute.sv
verilog/lc3b_memory.sv
verilog/lc3b_writeback.sv
verilog/lc3b_pipeline.sv
tb/lc3b_clock_gen.sv
tb/lc3b_pipeline_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module lc3b_pipeline_tb \
    -f lc3b_pipeline.f -o lc3b_pipeline_sim > build.log 2>&1 &&
    ./obj_dir/lc3b_pipeline_sim > sim.log 2>&1 ||
    echo "build or simulation stopped early, see build.log" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0
